//--- include/fll_defines.svh
`ifndef FLL_DEFINES_SVH
`define FLL_DEFINES_SVH

// Width of the APB address bus.
`define FLL_APB_ADDR_WIDTH 12

// Number of FLL configuration ports.
`define FLL_NUM 3

// Word index of the lock status register, offset 0x3C.
`define FLL_STATUS_IDX 15

// Cycles to wait for an ack before the access is aborted.
`define FLL_ACK_TIMEOUT 64

`endif

//--- verilog/fll_pkg.sv
package fll_pkg;

	// Request carried to one FLL configuration port.
	typedef struct packed {
		logic wrn; // 1 means read.
		logic [1:0] add;
		logic [31:0] data;
	} fll_req_t;

	// Word address split into FLL select and register index.
	typedef struct packed {
		logic [1:0] unit; // 3 is status or unmapped.
		logic [1:0] reg_idx;
	} fll_addr_f_t;

	// PADDR[5:2] as a raw word index or as fields.
	typedef union packed {
		logic [3:0] raw;
		fll_addr_f_t f;
	} fll_addr_u;

	typedef enum logic [2:0] {
		IDLE,
		REQ,
		WAIT_DROP,
		ABORT
	} fll_state_e;

endpackage

//--- verilog/fll_sync.sv
`timescale 1ns/10ps
`include "fll_defines.svh"

module fll_sync (
	input logic HCLK,
	input logic HRESETn,
	input logic [`FLL_NUM-1:0] ack,
	input logic [`FLL_NUM-1:0] lock,
	output logic [`FLL_NUM-1:0] ack_sync,
	output logic [`FLL_NUM-1:0] lock_sync
);

	localparam int W = 2 * `FLL_NUM;

	logic [W-1:0] stage0;
	logic [W-1:0] stage1;

	// Both flop stages clear on reset so nothing reads as acked or locked.
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			stage0 <= '0;
			stage1 <= '0;
		end else begin
			stage0 <= {lock, ack}; // May go metastable.
			stage1 <= stage0;
		end
	end

	assign ack_sync = stage1[`FLL_NUM-1:0];
	assign lock_sync = stage1[W-1:`FLL_NUM];

endmodule

//--- verilog/fll_ack_timer.sv
`timescale 1ns/10ps
`include "fll_defines.svh"

module fll_ack_timer (
	input logic HCLK,
	input logic HRESETn,
	input logic run,
	output logic expired
);

	localparam int CNT_W = $clog2(`FLL_ACK_TIMEOUT + 1);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`FLL_ACK_TIMEOUT);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			cnt <= '0;
		end else if (!run) begin
			cnt <= '0; // Restart between accesses.
		end else if (cnt != CNT_MAX) begin
			cnt <= cnt + 1'b1;
		end
	end

	assign expired = (cnt == CNT_MAX); // Holds while saturated.

	// The count only advances under run, so a rise needs run the cycle before.
	a_no_rise_idle: assert property (
		@(posedge HCLK) disable iff (!HRESETn)
		$rose(expired) |-> $past(run)
	);

endmodule

//--- verilog/fll_hs_fsm.sv
`timescale 1ns/10ps
`include "fll_defines.svh"

module fll_hs_fsm (
	input logic HCLK,
	input logic HRESETn,
	input logic access,
	input logic [1:0] unit,
	input fll_pkg::fll_req_t req_in,
	input logic [`FLL_NUM-1:0] ack_sync,
	input logic expired,
	output logic run,
	output logic done,
	output logic err,
	output logic [`FLL_NUM-1:0] fll_req,
	output fll_pkg::fll_req_t [`FLL_NUM-1:0] fll_bus
);

	fll_pkg::fll_state_e state;
	fll_pkg::fll_state_e state_nxt;
	logic [1:0] unit_q;
	logic ack_sel;

	// FLL index held for the whole handshake.
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			state <= fll_pkg::IDLE;
			unit_q <= '0;
		end else begin
			state <= state_nxt;
			if (state == fll_pkg::IDLE && access)
				unit_q <= unit;
		end
	end

	assign ack_sel = ack_sync[unit_q];

	always_comb begin
		state_nxt = state;
		case (state)
			fll_pkg::IDLE: begin
				if (access)
					state_nxt = fll_pkg::REQ;
			end
			fll_pkg::REQ: begin
				if (ack_sel)
					state_nxt = fll_pkg::WAIT_DROP;
				else if (expired)
					state_nxt = fll_pkg::ABORT;
			end
			fll_pkg::WAIT_DROP, fll_pkg::ABORT: begin
				// Ack must fall before the next req.
				if (!ack_sel)
					state_nxt = fll_pkg::IDLE;
			end
			default: state_nxt = fll_pkg::IDLE;
		endcase
	end

	assign run = (state == fll_pkg::REQ);
	assign done = run && ack_sel;
	assign err = run && !ack_sel && expired;

	// Only the selected FLL sees a request.
	always_comb begin
		for (int i = 0; i < `FLL_NUM; i++) begin
			fll_req[i] = run && (unit_q == 2'(i));
			if (fll_req[i]) begin
				fll_bus[i] = req_in;
			end else begin
				fll_bus[i].wrn = 1'b1;
				fll_bus[i].add = '0;
				fll_bus[i].data = '0;
			end
		end
	end

	// A running handshake drives exactly one req.
	a_one_req: assert property (
		@(posedge HCLK) disable iff (!HRESETn)
		run |-> $onehot(fll_req)
	);

	for (genvar g = 0; g < `FLL_NUM; g++) begin : g_hs_chk
		// A new req needs the previous ack to have fully dropped.
		a_req_after_drop: assert property (
			@(posedge HCLK) disable iff (!HRESETn)
			$rose(fll_req[g]) |-> !ack_sync[g]
		);
	end

endmodule

//--- verilog/fll_apb_decode.sv
`timescale 1ns/10ps
`include "fll_defines.svh"

module fll_apb_decode (
	input logic HCLK,
	input logic HRESETn,
	input logic [`FLL_APB_ADDR_WIDTH-1:0] PADDR,
	input logic PWRITE,
	input logic PSEL,
	input logic PENABLE,
	input logic [31:0] PWDATA,
	input logic [`FLL_NUM-1:0][31:0] r_data,
	input logic [`FLL_NUM-1:0] lock_sync,
	input logic done,
	input logic err,
	output logic access,
	output logic [1:0] unit,
	output fll_pkg::fll_req_t req_out,
	output logic [31:0] PRDATA,
	output logic PREADY,
	output logic PSLVERR
);

	fll_pkg::fll_addr_u addr;
	logic apb_access;
	logic mapped;
	logic status_hit;

	assign addr = PADDR[5:2];
	assign apb_access = PSEL && PENABLE;
	assign mapped = (addr.f.unit != 2'd3);
	assign status_hit = (addr.raw == 4'(`FLL_STATUS_IDX));

	assign access = apb_access && mapped;
	assign unit = addr.f.unit;

	always_comb begin
		req_out.wrn = ~PWRITE;
		req_out.add = addr.f.reg_idx;
		req_out.data = PWDATA;
	end

	// Read data mux.
	always_comb begin
		PRDATA = '0;
		if (apb_access && !PWRITE) begin
			if (mapped)
				PRDATA = r_data[addr.f.unit];
			else if (status_hit)
				PRDATA[`FLL_NUM-1:0] = lock_sync; // Lock levels.
		end
	end

	// FLL accesses wait on the handshake, everything else is immediate.
	always_comb begin
		PREADY = 1'b0;
		if (apb_access) begin
			if (mapped)
				PREADY = done || err;
			else
				PREADY = 1'b1;
		end
	end

	assign PSLVERR = err;

	// The FSM steers PADDR straight through, so it must not move mid-access.
	a_addr_stable: assert property (
		@(posedge HCLK) disable iff (!HRESETn)
		(access && !PREADY) |=> $stable(PADDR)
	);

endmodule

//--- verilog/fll_ctrl_top.sv
`timescale 1ns/10ps
`include "fll_defines.svh"

module fll_ctrl_top (
	input logic HCLK,
	input logic HRESETn,
	input logic [`FLL_APB_ADDR_WIDTH-1:0] PADDR,
	input logic [31:0] PWDATA,
	input logic PWRITE,
	input logic PSEL,
	input logic PENABLE,
	output logic [31:0] PRDATA,
	output logic PREADY,
	output logic PSLVERR,
	output logic fll1_req,
	output logic fll1_wrn,
	output logic [1:0] fll1_add,
	output logic [31:0] fll1_data,
	input logic fll1_ack,
	input logic [31:0] fll1_r_data,
	input logic fll1_lock,
	output logic fll2_req,
	output logic fll2_wrn,
	output logic [1:0] fll2_add,
	output logic [31:0] fll2_data,
	input logic fll2_ack,
	input logic [31:0] fll2_r_data,
	input logic fll2_lock,
	output logic fll3_req,
	output logic fll3_wrn,
	output logic [1:0] fll3_add,
	output logic [31:0] fll3_data,
	input logic fll3_ack,
	input logic [31:0] fll3_r_data,
	input logic fll3_lock
);

	logic [`FLL_NUM-1:0] ack_sync;
	logic [`FLL_NUM-1:0] lock_sync;
	logic [`FLL_NUM-1:0] fll_req;
	fll_pkg::fll_req_t [`FLL_NUM-1:0] fll_bus;
	fll_pkg::fll_req_t req;
	logic [1:0] unit;
	logic access;
	logic done;
	logic err;
	logic run;
	logic expired;

	fll_sync u_sync (
		.HCLK(HCLK),
		.HRESETn(HRESETn),
		.ack({fll3_ack, fll2_ack, fll1_ack}),
		.lock({fll3_lock, fll2_lock, fll1_lock}),
		.ack_sync(ack_sync),
		.lock_sync(lock_sync)
	);

	fll_ack_timer u_timer (
		.HCLK(HCLK),
		.HRESETn(HRESETn),
		.run(run),
		.expired(expired)
	);

	fll_hs_fsm u_fsm (
		.HCLK(HCLK),
		.HRESETn(HRESETn),
		.access(access),
		.unit(unit),
		.req_in(req),
		.ack_sync(ack_sync),
		.expired(expired),
		.run(run),
		.done(done),
		.err(err),
		.fll_req(fll_req),
		.fll_bus(fll_bus)
	);

	fll_apb_decode u_decode (
		.HCLK(HCLK),
		.HRESETn(HRESETn),
		.PADDR(PADDR),
		.PWRITE(PWRITE),
		.PSEL(PSEL),
		.PENABLE(PENABLE),
		.PWDATA(PWDATA),
		.r_data({fll3_r_data, fll2_r_data, fll1_r_data}),
		.lock_sync(lock_sync),
		.done(done),
		.err(err),
		.access(access),
		.unit(unit),
		.req_out(req),
		.PRDATA(PRDATA),
		.PREADY(PREADY),
		.PSLVERR(PSLVERR)
	);

	assign {fll3_req, fll2_req, fll1_req} = fll_req;

	// Request buses out to the FLL pins.
	assign fll1_wrn = fll_bus[0].wrn;
	assign fll1_add = fll_bus[0].add;
	assign fll1_data = fll_bus[0].data;
	assign fll2_wrn = fll_bus[1].wrn;
	assign fll2_add = fll_bus[1].add;
	assign fll2_data = fll_bus[1].data;
	assign fll3_wrn = fll_bus[2].wrn;
	assign fll3_add = fll_bus[2].add;
	assign fll3_data = fll_bus[2].data;

endmodule

//--- dv/fll_model.sv
`timescale 1ns/10ps

module fll_model (
	input logic clk,
	input logic enable_ack,
	input logic [4:0] ack_delay,
	input logic lock_in,
	input logic req,
	input logic wrn,
	input logic [1:0] add,
	input logic [31:0] data,
	output logic ack,
	output logic [31:0] r_data,
	output logic lock
);

	logic [31:0] regs [4];
	logic [4:0] wait_cnt;

	initial begin
		ack = 1'b0;
		r_data = '0;
		wait_cnt = '0;
		for (int i = 0; i < 4; i++)
			regs[i] = '0;
	end

	assign lock = lock_in;

	// Outputs move on the falling edge, like the rest of the stimulus.
	always @(negedge clk) begin
		if (!req) begin
			wait_cnt <= '0;
			ack <= 1'b0; // Fourth phase.
		end else if (!ack && enable_ack) begin
			if (wait_cnt >= ack_delay) begin
				if (wrn)
					r_data <= regs[add];
				else
					regs[add] <= data;
				ack <= 1'b1;
			end else begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

endmodule

//--- dv/fll_tb.sv
`timescale 1ns/10ps
`include "fll_defines.svh"

module fll_tb;

	localparam int WAIT_LIMIT = `FLL_ACK_TIMEOUT + 64;

	logic HCLK;
	logic HRESETn;
	logic [`FLL_APB_ADDR_WIDTH-1:0] PADDR;
	logic [31:0] PWDATA;
	logic PWRITE;
	logic PSEL;
	logic PENABLE;
	wire [31:0] PRDATA;
	wire PREADY;
	wire PSLVERR;

	wire [2:0] fll_req;
	wire [2:0] fll_wrn;
	wire [1:0] fll_add [3];
	wire [31:0] fll_data [3];
	wire [2:0] fll_ack;
	wire [31:0] fll_rdata [3];
	wire [2:0] fll_lock;

	logic [2:0] ack_en;
	logic [2:0] lock_lvl;
	logic [4:0] ack_dly [3];
	logic [31:0] ref_regs [12]; // Expected FLL register contents.
	logic [31:0] lfsr;

	fll_ctrl_top dut0 (
		.HCLK(HCLK), .HRESETn(HRESETn),
		.PADDR(PADDR), .PWDATA(PWDATA), .PWRITE(PWRITE), .PSEL(PSEL), .PENABLE(PENABLE),
		.PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
		.fll1_req(fll_req[0]), .fll1_wrn(fll_wrn[0]), .fll1_add(fll_add[0]),
		.fll1_data(fll_data[0]), .fll1_ack(fll_ack[0]), .fll1_r_data(fll_rdata[0]),
		.fll1_lock(fll_lock[0]),
		.fll2_req(fll_req[1]), .fll2_wrn(fll_wrn[1]), .fll2_add(fll_add[1]),
		.fll2_data(fll_data[1]), .fll2_ack(fll_ack[1]), .fll2_r_data(fll_rdata[1]),
		.fll2_lock(fll_lock[1]),
		.fll3_req(fll_req[2]), .fll3_wrn(fll_wrn[2]), .fll3_add(fll_add[2]),
		.fll3_data(fll_data[2]), .fll3_ack(fll_ack[2]), .fll3_r_data(fll_rdata[2]),
		.fll3_lock(fll_lock[2])
	);

	fll_model fll_m1 (
		.clk(HCLK), .enable_ack(ack_en[0]), .ack_delay(ack_dly[0]), .lock_in(lock_lvl[0]),
		.req(fll_req[0]), .wrn(fll_wrn[0]), .add(fll_add[0]), .data(fll_data[0]),
		.ack(fll_ack[0]), .r_data(fll_rdata[0]), .lock(fll_lock[0])
	);

	fll_model fll_m2 (
		.clk(HCLK), .enable_ack(ack_en[1]), .ack_delay(ack_dly[1]), .lock_in(lock_lvl[1]),
		.req(fll_req[1]), .wrn(fll_wrn[1]), .add(fll_add[1]), .data(fll_data[1]),
		.ack(fll_ack[1]), .r_data(fll_rdata[1]), .lock(fll_lock[1])
	);

	fll_model fll_m3 (
		.clk(HCLK), .enable_ack(ack_en[2]), .ack_delay(ack_dly[2]), .lock_in(lock_lvl[2]),
		.req(fll_req[2]), .wrn(fll_wrn[2]), .add(fll_add[2]), .data(fll_data[2]),
		.ack(fll_ack[2]), .r_data(fll_rdata[2]), .lock(fll_lock[2])
	);

	initial begin
		HCLK = 1'b0;
		forever #4 HCLK = ~HCLK;
	end

	// Fibonacci LFSR with taps 32 22 2 1.
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] val;
		logic fb;
		val = '0;
		for (int k = 0; k < n; k++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	task automatic stop_on_failure();
		$display("Some tests failed");
		$fatal(1, "Simulation stopped at the first failure.");
	endtask

	task automatic check_eq(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	// Only the addressed FLL may see req.
	task automatic verify_fll_buses(input logic mapped, input logic [1:0] sel,
		input logic [1:0] add, input logic write, input logic [31:0] wdata);
		for (int i = 0; i < 3; i++) begin
			if (mapped && sel == 2'(i) && fll_req[i]) begin
				check_eq($sformatf("fll%0d_wrn", i + 1), fll_wrn[i], !write);
				check_eq($sformatf("fll%0d_add", i + 1), fll_add[i], add);
				check_eq($sformatf("fll%0d_data", i + 1), fll_data[i], wdata);
			end else begin
				check_eq($sformatf("fll%0d_req", i + 1), fll_req[i], 1'b0);
				check_eq($sformatf("fll%0d_wrn", i + 1), fll_wrn[i], 1'b1);
				check_eq($sformatf("fll%0d_add", i + 1), fll_add[i], 2'd0);
				check_eq($sformatf("fll%0d_data", i + 1), fll_data[i], 32'd0);
			end
		end
	endtask

	task automatic apb_xfer(input logic [3:0] idx, input logic write,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic slverr);
		int cycles;
		logic ready;
		logic mapped;
		mapped = (idx < 4'd12);
		cycles = 0;
		ready = 1'b0;
		@(negedge HCLK);
		PADDR = {6'd0, idx, 2'b00};
		PWRITE = write;
		PWDATA = wdata;
		PSEL = 1'b1;
		PENABLE = 1'b0;
		@(negedge HCLK);
		PENABLE = 1'b1;
		// Pre-edge values at each rising edge of the access phase.
		while (!ready && cycles < WAIT_LIMIT) begin
			@(posedge HCLK);
			verify_fll_buses(mapped, idx[3:2], idx[1:0], write, wdata);
			ready = PREADY;
			rdata = PRDATA;
			slverr = PSLVERR;
			cycles++;
		end
		if (!ready) begin
			$display("Timeout: PREADY did not rise within %0d cycles of an APB access.",
				WAIT_LIMIT);
			stop_on_failure();
		end
		if (mapped) begin
			check_eq("selected req at PREADY", fll_req[idx[3:2]], 1'b1);
			// FSM step and two sync stages come first.
			check_eq("PREADY too early", 32'(cycles < 4), 32'd0);
		end else begin
			check_eq("PREADY wait cycles", cycles, 32'd1);
		end
		@(negedge HCLK);
		PSEL = 1'b0;
		PENABLE = 1'b0;
	endtask

	task automatic access_and_check(input logic [3:0] idx, input logic write,
		input logic [31:0] wdata);
		logic [31:0] rdata;
		logic slverr;
		for (int i = 0; i < 3; i++)
			ack_dly[i] = 5'(lfsr_bits(5) % 21);
		apb_xfer(idx, write, wdata, rdata, slverr);
		check_eq("PSLVERR", slverr, 1'b0);
		if (idx < 4'd12) begin
			if (write)
				ref_regs[idx] = wdata;
			else
				check_eq($sformatf("PRDATA reg %0d", idx), rdata, ref_regs[idx]);
		end else if (!write) begin
			check_eq("PRDATA unmapped", rdata, 32'd0);
		end
	endtask

	task automatic status_read_and_check();
		logic [31:0] rdata;
		logic slverr;
		lock_lvl = 3'(lfsr_bits(3));
		repeat (5) @(negedge HCLK); // Let the new levels through the synchronizer.
		apb_xfer(4'd15, 1'b0, 32'd0, rdata, slverr);
		check_eq("PRDATA status", rdata, {29'd0, lock_lvl});
		check_eq("PSLVERR", slverr, 1'b0);
	endtask

	task automatic abort_and_recover(input int v);
		logic [31:0] rdata;
		logic slverr;
		logic [3:0] idx;
		logic [3:0] idx2;
		idx = 4'(v * 4) + 4'(lfsr_bits(2));
		idx2 = 4'(((v + 1) % 3) * 4) + 4'(lfsr_bits(2));
		ack_en[v] = 1'b0;
		apb_xfer(idx, lfsr_bits(1), lfsr_bits(32), rdata, slverr);
		check_eq("PSLVERR on dead FLL", slverr, 1'b1);
		access_and_check(idx2, 1'b1, lfsr_bits(32));
		access_and_check(idx2, 1'b0, 32'd0);
		ack_en[v] = 1'b1;
		access_and_check(idx, 1'b0, 32'd0); // Aborted write must not land.
	endtask

	initial begin
		logic [3:0] idx;
		logic wr;
		lfsr = 32'hf860;
		PADDR = '0;
		PWDATA = '0;
		PWRITE = 1'b0;
		PSEL = 1'b0;
		PENABLE = 1'b0;
		ack_en = 3'b111;
		lock_lvl = 3'b000;
		for (int i = 0; i < 3; i++)
			ack_dly[i] = '0;
		for (int i = 0; i < 12; i++)
			ref_regs[i] = '0;
		HRESETn = 1'b0;
		repeat (16) @(negedge HCLK);
		HRESETn = 1'b1;

		for (int n = 0; n < 160; n++) begin
			idx = 4'(lfsr_bits(4));
			wr = lfsr_bits(1);
			if (idx == 4'd15 && !wr)
				status_read_and_check();
			else
				access_and_check(idx, wr, lfsr_bits(32));
		end

		// Every register still holds its last write.
		for (int i = 0; i < 12; i++)
			access_and_check(4'(i), 1'b0, 32'd0);

		for (int v = 0; v < 3; v++)
			abort_and_recover(v);

		status_read_and_check();
		$display("All tests passed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+include
verilog/fll_pkg.sv
verilog/fll_sync.sv
verilog/fll_ack_timer.sv
verilog/fll_hs_fsm.sv
verilog/fll_apb_decode.sv
verilog/fll_ctrl_top.sv
dv/fll_model.sv
dv/fll_tb.sv
